// ==== verilog/hist_pkg.sv ====
// ----------------------------------------------------------------------
// Histogram engine shared definitions
// Symbol width, counter bank geometry and dump sequencer states
// ----------------------------------------------------------------------

package hist_pkg;

    // Symbol as presented on the board pins
    parameter int SYM_W = 7;

    // Eight banks of sixteen bins cover all 128 symbol values
    parameter int NUM_BANKS = 8;
    parameter int BANK_BINS = 16;

    // End of stream marker, never counted
    parameter logic [SYM_W-1:0] END_SYM = '0;

    // Dump sequencer states
    typedef enum logic [2:0] {
        IDLE,   // Counting, waiting for end marker
        ADDR,   // Read address on banks, count latched
        WRITE,  // Wishbone cycle open until ACK
        NEXT,   // Step to next symbol or finish
        DONE,   // Done bit high, waiting for board ack
        CLEAR   // Zero all counters
    } dump_state_e;

endpackage

// ==== verilog/hist_intake.sv ====
// ----------------------------------------------------------------------
// Symbol intake
// Synchronizes the board read pulse and symbol lines, detects the
// pulse edge and splits counting symbols from the end marker
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module hist_intake (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     read_in_pulse, // Async strobe from board
    input  logic [hist_pkg::SYM_W-1:0] in_sym,      // Async symbol lines
    input  logic                     busy,          // Dump in progress
    output logic [hist_pkg::SYM_W-1:0] sym,
    output logic                     sym_valid,
    output logic                     end_seen
);

    logic                       pulse_s1;
    logic                       pulse_s2;
    logic                       pulse_d;   // Previous synced level
    logic [hist_pkg::SYM_W-1:0] sym_s1;
    logic [hist_pkg::SYM_W-1:0] sym_s2;
    logic                       pulse_rise;
    logic                       is_end;

    // Symbol lines are stable around the pulse so they share the sync
    always_ff @(posedge clk) begin
        sym_s1 <= in_sym;
        sym_s2 <= sym_s1;
        sym    <= sym_s2;   // Aligned with the strobes below
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pulse_s1  <= 1'b0;
            pulse_s2  <= 1'b0;
            pulse_d   <= 1'b0;
            sym_valid <= 1'b0;
            end_seen  <= 1'b0;
        end else begin
            pulse_s1  <= read_in_pulse;
            pulse_s2  <= pulse_s1;
            pulse_d   <= pulse_s2;
            // Edges during a dump are dropped
            sym_valid <= pulse_rise && !busy && !is_end;
            end_seen  <= pulse_rise && !busy && is_end;
        end
    end

    assign pulse_rise = pulse_s2 && !pulse_d; // Rising edge of synced pulse
    assign is_end     = (sym_s2 == hist_pkg::END_SYM);

endmodule

// ==== verilog/hist_bank.sv ====
// ----------------------------------------------------------------------
// Counter bank
// Sixteen saturating symbol counters with bulk clear and a
// combinational read port for the dump sequencer
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module hist_bank #(
    parameter int COUNT_W = 16
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      inc,      // Count one symbol
    input  logic [$clog2(hist_pkg::BANK_BINS)-1:0]    inc_bin,
    input  logic                                      clr,      // Zero every bin
    input  logic [$clog2(hist_pkg::BANK_BINS)-1:0]    rd_bin,
    output logic [COUNT_W-1:0]                        rd_count
);

    logic [COUNT_W-1:0] count [hist_pkg::BANK_BINS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < hist_pkg::BANK_BINS; i++) begin
                count[i] <= '0;
            end
        end else if (clr) begin
            // Clear wins over a same-cycle increment
            for (int i = 0; i < hist_pkg::BANK_BINS; i++) begin
                count[i] <= '0;
            end
        end else if (inc && (count[inc_bin] != '1)) begin
            count[inc_bin] <= count[inc_bin] + 1'b1; // Sticks at all ones
        end
    end

    // Read mux for the dump
    assign rd_count = count[rd_bin];

endmodule

// ==== verilog/hist_dump.sv ====
// ----------------------------------------------------------------------
// Histogram dump sequencer
// Walks all 128 bins, writes each count over Wishbone and then runs
// the done and acknowledge exchange with the board before clearing
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module hist_dump #(
    parameter int          COUNT_W   = 16,
    parameter logic [31:0] BASE_ADDR = 32'h3000_0000
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   end_seen,  // End marker from intake
    input  logic [COUNT_W-1:0]                     rd_count,  // Selected bank count
    input  logic                                   esp_ack,   // Async board ack
    input  logic                                   wb_ack,
    output logic [$clog2(hist_pkg::NUM_BANKS)-1:0] rd_bank,
    output logic [$clog2(hist_pkg::BANK_BINS)-1:0] rd_bin,
    output logic                                   clr,
    output logic                                   busy,
    output logic                                   write_bit, // Done flag to board
    output logic [31:0]                            wb_adr,
    output logic [31:0]                            wb_dat_o,
    output logic [3:0]                             wb_sel,
    output logic                                   wb_we,
    output logic                                   wb_stb,
    output logic                                   wb_cyc
);

    localparam int BIN_W = $clog2(hist_pkg::BANK_BINS);

    hist_pkg::dump_state_e      state;
    logic [hist_pkg::SYM_W-1:0] idx;       // Symbol being dumped
    logic                       ack_s1;
    logic                       ack_s2;
    logic                       ack_d;
    logic                       ack_rise;

    // Board acknowledge synchronizer and edge detect
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_s1 <= 1'b0;
            ack_s2 <= 1'b0;
            ack_d  <= 1'b0;
        end else begin
            ack_s1 <= esp_ack;
            ack_s2 <= ack_s1;
            ack_d  <= ack_s2;
        end
    end

    assign ack_rise = ack_s2 && !ack_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= hist_pkg::IDLE;
            idx       <= '0;
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            wb_we     <= 1'b0;
            write_bit <= 1'b0;
        end else begin
            case (state)
                hist_pkg::IDLE: begin
                    if (end_seen) begin
                        idx   <= '0;    // Symbol 0 goes out first
                        state <= hist_pkg::ADDR;
                    end
                end
                hist_pkg::ADDR: begin
                    // Count is on rd_count now, open the bus cycle
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                    wb_we  <= 1'b1;
                    state  <= hist_pkg::WRITE;
                end
                hist_pkg::WRITE: begin
                    if (wb_ack) begin   // Hold everything until the slave takes it
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        state  <= hist_pkg::NEXT;
                    end
                end
                hist_pkg::NEXT: begin
                    if (idx == '1) begin
                        write_bit <= 1'b1;  // Last bin written
                        state     <= hist_pkg::DONE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= hist_pkg::ADDR;
                    end
                end
                hist_pkg::DONE: begin
                    // Only a fresh ack edge releases the done flag
                    if (ack_rise) begin
                        state <= hist_pkg::CLEAR;
                    end
                end
                hist_pkg::CLEAR: begin
                    write_bit <= 1'b0;
                    state     <= hist_pkg::IDLE;
                end
                default: begin
                    state <= hist_pkg::IDLE;
                end
            endcase
        end
    end

    // Bus payload captured with the count in ADDR
    always_ff @(posedge clk) begin
        if (state == hist_pkg::ADDR) begin
            wb_adr   <= BASE_ADDR + {23'd0, idx, 2'b00}; // One word per symbol
            wb_dat_o <= 32'(rd_count);                   // Zero extended
        end
    end

    assign wb_sel  = 4'hf;                           // Full word writes
    assign rd_bank = idx[hist_pkg::SYM_W-1:BIN_W];   // Upper bits pick bank
    assign rd_bin  = idx[BIN_W-1:0];
    assign clr     = (state == hist_pkg::CLEAR);
    assign busy    = (state != hist_pkg::IDLE);      // ADDR through CLEAR

endmodule

// ==== verilog/team_05.sv ====
// ----------------------------------------------------------------------
// Symbol histogram chip top
// Maps board gpio pins, folds the enable into reset and ties the
// intake, the counter banks and the Wishbone dump sequencer together
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module team_05 #(
    parameter int          COUNT_W   = 16,
    parameter logic [31:0] BASE_ADDR = 32'h3000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,        // Chip enable, low acts as reset
    input  logic [33:0] gpio_in,   // Board pins
    output logic [33:0] gpio_out,
    output logic [33:0] gpio_oeb,  // Active low output enable
    input  logic [31:0] DAT_I,     // Read data, no reads issued
    input  logic        ACK_I,
    output logic [31:0] ADR_O,
    output logic [31:0] DAT_O,
    output logic [3:0]  SEL_O,
    output logic        WE_O,
    output logic        STB_O,
    output logic        CYC_O
);

    localparam int BIN_W  = $clog2(hist_pkg::BANK_BINS);
    localparam int BANK_W = $clog2(hist_pkg::NUM_BANKS);

    logic                       sys_rst_n;
    logic [hist_pkg::SYM_W-1:0] sym;
    logic                       sym_valid;
    logic                       end_seen;
    logic                       busy;
    logic                       clr;
    logic                       write_bit;
    logic [BANK_W-1:0]          rd_bank;
    logic [BIN_W-1:0]           rd_bin;
    logic [COUNT_W-1:0]         rd_count;
    logic [COUNT_W-1:0]         bank_count [hist_pkg::NUM_BANKS];

    // Either reset or a low enable holds the design in reset
    assign sys_rst_n = rst_n && en;

    // Pin map
    assign gpio_out = {32'd0, write_bit, 1'b0};   // Done flag on bit 1
    assign gpio_oeb = {{32{1'b1}}, 1'b0, 1'b1};   // Only bit 1 driven

    hist_intake i_intake (
        .clk           (clk),
        .rst_n         (sys_rst_n),
        .read_in_pulse (gpio_in[3]),
        .in_sym        (gpio_in[10:4]),
        .busy          (busy),
        .sym           (sym),
        .sym_valid     (sym_valid),
        .end_seen      (end_seen)
    );

    for (genvar b = 0; b < hist_pkg::NUM_BANKS; b++) begin : g_bank
        logic bank_inc;

        // Bank select from the upper symbol bits
        assign bank_inc = sym_valid && (sym[hist_pkg::SYM_W-1:BIN_W] == BANK_W'(b));

        hist_bank #(
            .COUNT_W (COUNT_W)
        ) i_bank (
            .clk      (clk),
            .rst_n    (sys_rst_n),
            .inc      (bank_inc),
            .inc_bin  (sym[BIN_W-1:0]),
            .clr      (clr),
            .rd_bin   (rd_bin),
            .rd_count (bank_count[b])
        );
    end

    assign rd_count = bank_count[rd_bank];  // Count back to the dump

    hist_dump #(
        .COUNT_W   (COUNT_W),
        .BASE_ADDR (BASE_ADDR)
    ) i_dump (
        .clk       (clk),
        .rst_n     (sys_rst_n),
        .end_seen  (end_seen),
        .rd_count  (rd_count),
        .esp_ack   (gpio_in[2]),
        .wb_ack    (ACK_I),
        .rd_bank   (rd_bank),
        .rd_bin    (rd_bin),
        .clr       (clr),
        .busy      (busy),
        .write_bit (write_bit),
        .wb_adr    (ADR_O),
        .wb_dat_o  (DAT_O),
        .wb_sel    (SEL_O),
        .wb_we     (WE_O),
        .wb_stb    (STB_O),
        .wb_cyc    (CYC_O)
    );

endmodule

// ==== verif/tb_wb_slave.sv ====
// ----------------------------------------------------------------------
// Wishbone memory responder for the histogram testbench
// Random wait states, stores each write and checks the address order
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_wb_slave #(
    parameter logic [31:0] BASE_ADDR = 32'h3000_0000,
    parameter logic [31:0] SEED      = 32'h0000_0001
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] dat,
    output logic        ack
);

    logic [31:0] mem [128];     // One word per symbol
    logic [31:0] rand_state;
    logic [1:0]  waits;         // Wait states left for the open cycle
    logic [6:0]  exp_sym;       // Symbol the next write should carry
    logic [31:0] exp_adr;       // Byte address of that symbol's word
    int          write_count;
    int          addr_errors;

    function automatic logic [31:0] step_lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign exp_adr = BASE_ADDR + 32'(exp_sym) * 32'd4;   // Four bytes per word

    always @(posedge clk) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            rand_state  <= SEED;
            waits       <= 2'd0;
            exp_sym     <= 7'd0;
            write_count <= 0;
            addr_errors <= 0;
        end else if (ack) begin
            ack        <= 1'b0;
            rand_state <= step_lcg(rand_state);
            waits      <= rand_state[17:16];   // 0 to 3 for the next cycle
            if (cyc && stb && we) begin
                assert (adr == exp_adr) else begin
                    $display("ERR ADR_O got=%h exp=%h", adr, exp_adr);
                    addr_errors <= addr_errors + 1;
                end
                mem[adr[8:2]] <= dat;
                exp_sym       <= exp_sym + 7'd1;   // Wraps for the next dump
                write_count   <= write_count + 1;
            end
        end else if (cyc && stb) begin
            if (waits == 2'd0) begin
                ack <= 1'b1;
            end else begin
                waits <= waits - 2'd1;
            end
        end
    end

endmodule

// ==== verif/tb_team_05.sv ====
// ----------------------------------------------------------------------
// Histogram chip testbench
// Streams symbols onto the board pins and checks the Wishbone dump,
// the done handshake, clearing, saturation and enable as reset
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_team_05;

    localparam int          COUNT_W     = 8;
    localparam logic [31:0] BASE_ADDR   = 32'h3000_0000;
    localparam int          SYM_SLOTS   = 640;  // Every symbol sent, dropped ones too
    localparam int          DUMPS       = 5;
    localparam int          WATCHDOG_NS = SYM_SLOTS * 60 + DUMPS * 128 * 80 + 20000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        en;
    logic [33:0] gpio_in;
    logic [33:0] gpio_out;
    logic [33:0] gpio_oeb;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_o;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;

    logic [7:0]  ref_count [128];   // Expected counts, stick at 255
    logic [31:0] rand_state;
    logic        ack_sent;          // Board ack given in this round
    int          check_errors;
    int          bus_errors = 0;
    int          tests_run;
    int          tests_failed;

    logic        prev_live = 1'b0;  // Reset and enable high at last edge
    logic        prev_en   = 1'b1;
    logic        prev_hold = 1'b0;  // Cycle open without ACK
    logic        prev_ack  = 1'b0;
    logic        prev_done = 1'b0;
    logic [31:0] prev_adr  = '0;
    logic [31:0] prev_dat  = '0;

    always #5 clk = ~clk;

    team_05 #(
        .COUNT_W   (COUNT_W),
        .BASE_ADDR (BASE_ADDR)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oeb (gpio_oeb),
        .DAT_I    (wb_dat_i),
        .ACK_I    (wb_ack),
        .ADR_O    (wb_adr),
        .DAT_O    (wb_dat_o),
        .SEL_O    (wb_sel),
        .WE_O     (wb_we),
        .STB_O    (wb_stb),
        .CYC_O    (wb_cyc)
    );

    tb_wb_slave #(
        .BASE_ADDR (BASE_ADDR),
        .SEED      (32'hb0cb8f9e)
    ) i_slave (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (wb_cyc),
        .stb   (wb_stb),
        .we    (wb_we),
        .adr   (wb_adr),
        .dat   (wb_dat_o),
        .ack   (wb_ack)
    );

    // Bus and done flag rules, sampled on the rising edge
    always @(posedge clk) begin
        if (prev_live && rst_n && en) begin
            if (prev_hold) begin
                assert (wb_cyc && wb_stb && wb_adr == prev_adr && wb_dat_o == prev_dat) else begin
                    $display("ERR CYC_O=%h STB_O=%h ADR_O=%h DAT_O=%h changed before ACK",
                             wb_cyc, wb_stb, wb_adr, wb_dat_o);
                    bus_errors++;
                end
            end
            if (prev_ack) begin
                assert (!wb_cyc && !wb_stb) else begin
                    $display("ERR CYC_O=%h STB_O=%h exp=0 after ACK", wb_cyc, wb_stb);
                    bus_errors++;
                end
            end
            if (prev_done && !gpio_out[1]) begin
                assert (ack_sent) else begin
                    $display("done flag fell without a board acknowledge");
                    bus_errors++;
                end
            end
            if (gpio_out[1] && !prev_done) begin  // Done only after symbol 127
                assert (wb_adr == BASE_ADDR + 32'h1fc) else begin
                    $display("ERR ADR_O got=%h exp=%h at done", wb_adr, BASE_ADDR + 32'h1fc);
                    bus_errors++;
                end
            end
        end
        if (rst_n) begin
            if (wb_cyc) begin
                assert (wb_stb && wb_we && wb_sel == 4'hf) else begin
                    $display("ERR STB_O=%h WE_O=%h SEL_O=%h", wb_stb, wb_we, wb_sel);
                    bus_errors++;
                end
            end
            if (gpio_out[1]) begin
                assert (!wb_cyc) else begin
                    $display("ERR CYC_O=%h exp=0 while done", wb_cyc);
                    bus_errors++;
                end
            end
            if (!prev_en) begin  // Low enable resets the chip
                assert (!wb_cyc && !wb_stb && !gpio_out[1]) else begin
                    $display("ERR CYC_O=%h STB_O=%h write_bit=%h exp=0 with en low",
                             wb_cyc, wb_stb, gpio_out[1]);
                    bus_errors++;
                end
            end
        end
        assert (gpio_oeb == 34'h3_ffff_fffd && gpio_out[33:2] == '0 && !gpio_out[0]) else begin
            $display("ERR gpio_oeb=%h gpio_out=%h", gpio_oeb, gpio_out);
            bus_errors++;
        end
        prev_live <= rst_n && en;
        prev_en   <= en;
        prev_hold <= wb_cyc && !wb_ack;
        prev_ack  <= wb_ack;
        prev_done <= gpio_out[1];
        prev_adr  <= wb_adr;
        prev_dat  <= wb_dat_o;
    end

    function automatic logic [6:0] next_symbol();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return 7'((rand_state >> 16) % 32'd127) + 7'd1;   // Never the end marker
    endfunction

    function automatic int error_total();
        return check_errors + bus_errors + i_slave.addr_errors;
    endfunction

    // Called on a falling edge, returns on one 6 cycles later
    task automatic send_symbol(input logic [6:0] s, input logic counted);
        gpio_in[10:4] = s;
        gpio_in[3]    = 1'b1;
        repeat (2) @(negedge clk);
        gpio_in[3]    = 1'b0;
        repeat (4) @(negedge clk);
        if (counted && s != hist_pkg::END_SYM && ref_count[s] != 8'hff) begin
            ref_count[s] = ref_count[s] + 8'd1;
        end
    endtask

    task automatic send_random(input int n, input logic counted);
        for (int i = 0; i < n; i++) begin
            send_symbol(next_symbol(), counted);
        end
    endtask

    task automatic clear_reference();
        for (int i = 0; i < 128; i++) begin
            ref_count[7'(i)] = 8'd0;
        end
    endtask

    // End marker, then wait for the done flag
    task automatic run_dump();
        ack_sent = 1'b0;
        send_symbol(hist_pkg::END_SYM, 1'b0);
        while (!gpio_out[1]) @(negedge clk);
    endtask

    task automatic acknowledge_board();
        ack_sent   = 1'b1;
        gpio_in[2] = 1'b1;
        repeat (3) @(negedge clk);
        gpio_in[2] = 1'b0;
        while (gpio_out[1]) @(negedge clk);
    endtask

    task automatic check_memory();
        logic [6:0] s;
        for (int i = 0; i < 128; i++) begin
            s = 7'(i);
            assert (i_slave.mem[s] == {24'd0, ref_count[s]}) else begin
                $display("ERR mem[%h] got=%h exp=%h", s, i_slave.mem[s], ref_count[s]);
                check_errors++;
            end
        end
    endtask

    task automatic check_writes(input int n);
        assert (i_slave.write_count == n) else begin
            $display("ERR write_count got=%h exp=%h", i_slave.write_count, n);
            check_errors++;
        end
    endtask

    task automatic report_test(input string name, input int failures);
        tests_run++;
        if (failures == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, name, failures);
        end
    endtask

    initial begin
        int errs;
        logic [6:0] sat_sym;
        rst_n        = 1'b0;
        en           = 1'b1;
        gpio_in      = '0;
        wb_dat_i     = '0;
        rand_state   = 32'hb0cb8f9e;
        ack_sent     = 1'b0;
        check_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        clear_reference();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        errs = check_errors;
        send_random(200, 1'b1);
        run_dump();
        check_memory();
        report_test("random stream", check_errors - errs);

        errs = check_errors;
        check_writes(128);
        report_test("write order and bus signals",
                    check_errors - errs + bus_errors + i_slave.addr_errors);

        errs = error_total();
        repeat (20) @(negedge clk);
        send_random(4, 1'b0);   // Dropped while done is high
        assert (gpio_out[1]) else begin
            $display("ERR write_bit got=%h exp=1 before ack", gpio_out[1]);
            check_errors++;
        end
        acknowledge_board();
        repeat (5) @(negedge clk);
        assert (!gpio_out[1]) else begin
            $display("ERR write_bit got=%h exp=0 after ack", gpio_out[1]);
            check_errors++;
        end
        report_test("done handshake", error_total() - errs);

        errs = error_total();
        clear_reference();
        send_random(100, 1'b1);
        run_dump();
        check_memory();
        check_writes(256);
        acknowledge_board();
        report_test("clearing and dropping", error_total() - errs);

        errs = error_total();
        clear_reference();
        sat_sym = next_symbol();
        for (int i = 0; i < 300; i++) begin
            send_symbol(sat_sym, 1'b1);
        end
        run_dump();
        check_memory();     // Bin sat_sym expected at 255
        acknowledge_board();
        report_test("saturation", error_total() - errs);

        errs = error_total();
        clear_reference();
        send_random(20, 1'b1);
        run_dump();
        check_memory();
        en = 1'b0;          // Counts still held, no clear yet
        clear_reference();
        repeat (2) @(negedge clk);
        assert (!wb_cyc && !wb_stb && !gpio_out[1]) else begin
            $display("ERR CYC_O=%h STB_O=%h write_bit=%h with en low",
                     wb_cyc, wb_stb, gpio_out[1]);
            check_errors++;
        end
        repeat (3) @(negedge clk);
        en = 1'b1;
        @(negedge clk);
        run_dump();
        check_memory();     // All zeros after the enable reset
        check_writes(640);
        acknowledge_board();
        report_test("enable as reset", error_total() - errs);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
        if (tests_failed == 0 && error_total() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Bounded by stream lengths and dump count
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, DUT stalled", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/hist_pkg.sv
verilog/hist_intake.sv
verilog/hist_bank.sv
verilog/hist_dump.sv
verilog/team_05.sv
verif/tb_wb_slave.sv
verif/tb_team_05.sv

// ==== Makefile ====
# Verilator build and run for the histogram chip testbench

TOP = tb_team_05

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
